/* all.f */
+incdir+include
verilog/mat_pkg.sv
verilog/mat_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/matrix_parser.sv
verilog/matrix_store.sv
verilog/matrix_printer.sv
verilog/mat_top.sv
sim/tb_mat_top.sv

/* include/mat_consts.svh */
/*
 * matrix front end constants
 * sizes, serial bit timing and the ASCII codes of the text format
 */
`ifndef MAT_CONSTS_SVH
`define MAT_CONSTS_SVH

// ========================================
// matrix geometry
`define MAT_MAX_DIM        5      // rows or cols upper bound
`define MAT_SLOTS          2      // ring store depth
`define MAT_ELEM_BITS      4      // one decimal digit

// serial line
`define UART_CLKS_PER_BIT  8

// ========================================
// character codes
`define ASCII_ZERO         8'h30
`define ASCII_SPACE        8'h20
`define ASCII_CR           8'h0D
`define ASCII_LF           8'h0A

`endif

/* run.sh */
#!/bin/sh
# build and run the matrix front end testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_mat_top -o tb_mat_top > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/tb_mat_top > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^No errors$" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* sim/tb_mat_top.sv */
/*
 * matrix front end testbench
 * random matrices over the serial line, two-slot model, echo and print checks
 */
`timescale 1ns/1ps
`include "mat_consts.svh"

module tb_mat_top;

	localparam int CPB = `UART_CLKS_PER_BIT;
	localparam int FRAME = 10 * CPB;                          // cycles per serial byte
	localparam int MAX_CYCLES = 40 * 31 * 2 * FRAME + 51600;  // 250000 with margin
	localparam int unsigned SEED = 32'h547c7819;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       uart_rxd;
	logic       uart_txd;
	logic       print_req;
	logic       slot_sel;
	logic [1:0] stored_count;
	logic       parse_error;
	logic       rd_error;
	logic       print_busy;

	int cycles = 0;
	int errors;
	int checks;
	int test_base;     // error count when the test began
	int tests_run;
	int tests_failed;
	int perr_cnt = 0;  // parse_error pulses seen
	int rd_cnt = 0;    // rd_error pulses seen

	logic [7:0] rx_q[$];   // bytes seen on uart_txd
	logic [7:0] exp_q[$];  // bytes the model predicts

	// ========================================
	// reference model state
	int cur_rows;
	int cur_cols;
	int cur[25];           // next matrix to send in row-major order
	int m_rows[2];
	int m_cols[2];
	int m_elems[2][25];
	bit m_valid[2];
	int m_ptr;             // slot the next write lands in
	int m_count;

	mat_top dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.uart_rxd     (uart_rxd),
		.uart_txd     (uart_txd),
		.print_req    (print_req),
		.slot_sel     (slot_sel),
		.stored_count (stored_count),
		.parse_error  (parse_error),
		.rd_error     (rd_error),
		.print_busy   (print_busy)
	);

	always #20 clk = ~clk;   // 40 ns period

	// pulse counters and run limit
	always @(posedge clk) begin
		cycles++;
		if (rst_n && parse_error)
			perr_cnt++;
		if (rst_n && rd_error)
			rd_cnt++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run still going after %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// serial receiver on uart_txd sampling near mid-bit
	initial begin : txd_monitor
		logic [7:0] b;
		forever begin
			@(negedge clk);
			if (rst_n && !uart_txd) begin
				repeat (CPB / 2 - 1) @(negedge clk);   // middle of start bit
				for (int i = 0; i < 8; i++) begin
					repeat (CPB) @(negedge clk);
					b[i] = uart_txd;                // lsb first
				end
				repeat (CPB) @(negedge clk);
				checks++;
				assert (uart_txd == 1'b1) else begin
					$display("framing error @%0t: stop bit on uart_txd was low", $time);
					errors++;
				end
				rx_q.push_back(b);
			end
		end
	end

	// ========================================
	// checking and bookkeeping
	task automatic check_eq(input string what, input int got, input int want);
		checks++;
		assert (got == want) else begin
			$display("MISMATCH @%0t: %s is %0d, expected %0d", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic compare_text(input string what);
		int n;
		n = exp_q.size();
		check_eq({what, " byte count"}, rx_q.size(), n);
		if (rx_q.size() == n) begin
			for (int i = 0; i < n; i++) begin
				checks++;
				assert (rx_q[i] == exp_q[i]) else begin
					$display("MISMATCH @%0t: %s byte %0d is %h, expected %h",
						$time, what, i, rx_q[i], exp_q[i]);
					errors++;
				end
			end
		end
		rx_q.delete();
		exp_q.delete();
	endtask

	task automatic start_test();
		test_base = errors;
	endtask

	task automatic end_test(input int num, input string name);
		tests_run++;
		if (errors == test_base) begin
			$display("test %0d %s: pass", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAIL with %0d errors", num, name, errors - test_base);
		end
	endtask

	// ========================================
	// stimulus
	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		m_valid[0] = 1'b0;
		m_valid[1] = 1'b0;
		m_ptr      = 0;
		m_count    = 0;
		rx_q.delete();
		exp_q.delete();
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};   // stop, data, start
		@(negedge clk);
		for (int i = 0; i < 10; i++) begin
			uart_rxd = frame[i];
			repeat (CPB) @(negedge clk);
		end
	endtask

	task automatic random_matrix();
		cur_rows = 1 + $urandom % 5;
		cur_cols = 1 + $urandom % 5;
		for (int i = 0; i < 25; i++)
			cur[i] = $urandom % 10;
	endtask

	task automatic send_matrix();
		send_byte(`ASCII_ZERO + 8'(cur_rows));
		send_byte(`ASCII_ZERO + 8'(cur_cols));
		for (int i = 0; i < cur_rows * cur_cols; i++)
			send_byte(`ASCII_ZERO + 8'(cur[i]));
	endtask

	function automatic logic [7:0] random_non_digit();
		logic [7:0] b;
		b = 8'($urandom);
		while (b >= `ASCII_ZERO && b <= `ASCII_ZERO + 8'd9)
			b = 8'($urandom);
		return b;
	endfunction

	function automatic logic [7:0] bad_dim();
		return ($urandom % 2) ? `ASCII_ZERO + 8'd6 : `ASCII_ZERO;   // 0 or 6
	endfunction

	// expected text of one slot with spaces between digits and CR LF per row
	task automatic expect_slot(input int s);
		for (int r = 0; r < m_rows[s]; r++) begin
			for (int c = 0; c < m_cols[s]; c++) begin
				exp_q.push_back(`ASCII_ZERO + 8'(m_elems[s][r * m_cols[s] + c]));
				if (c != m_cols[s] - 1)
					exp_q.push_back(`ASCII_SPACE);
			end
			exp_q.push_back(`ASCII_CR);
			exp_q.push_back(`ASCII_LF);
		end
	endtask

	// ring write that also queues the echo text
	task automatic model_write();
		m_rows[m_ptr] = cur_rows;
		m_cols[m_ptr] = cur_cols;
		for (int i = 0; i < 25; i++)
			m_elems[m_ptr][i] = cur[i];
		m_valid[m_ptr] = 1'b1;
		expect_slot(m_ptr);
		m_ptr = 1 - m_ptr;
		if (m_count < `MAT_SLOTS)
			m_count++;
	endtask

	// printer done and txd idle for a whole frame
	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < FRAME) begin
			@(negedge clk);
			if (!print_busy && uart_txd)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic request_print(input int s);
		@(negedge clk);
		print_req = 1'b1;
		slot_sel  = s[0];
		@(negedge clk);
		print_req = 1'b0;
	endtask

	task automatic write_and_check(input string what);
		random_matrix();
		send_matrix();
		model_write();
		wait_quiet();
		compare_text(what);
		check_eq("stored_count", int'(stored_count), m_count);
	endtask

	// ========================================
	// test sequence
	initial begin
		int base_perr;
		int base_rd;
		int base_cnt;
		int mode;
		int k;
		void'($urandom(SEED));
		rst_n        = 1'b0;
		uart_rxd     = 1'b1;   // line idle
		print_req    = 1'b0;
		slot_sel     = 1'b0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		apply_reset();

		start_test();
		@(negedge clk);
		check_eq("uart_txd", int'(uart_txd), 1);
		check_eq("stored_count", int'(stored_count), 0);
		check_eq("parse_error", int'(parse_error), 0);
		check_eq("rd_error", int'(rd_error), 0);
		check_eq("print_busy", int'(print_busy), 0);
		end_test(1, "reset state");

		start_test();
		base_perr = perr_cnt;
		for (int m = 0; m < 12; m++)
			write_and_check("echo");
		check_eq("parse_error pulses", perr_cnt - base_perr, 0);
		end_test(2, "echo");

		start_test();
		apply_reset();                          // count starts below saturation
		for (int round = 0; round < 6; round++) begin
			base_cnt  = m_count;
			base_perr = perr_cnt;
			random_matrix();
			mode = $urandom % 3;
			if (mode == 0) begin
				send_byte(bad_dim());             // bad row count
			end else begin
				send_byte(`ASCII_ZERO + 8'(cur_rows));
				if (mode == 1) begin
					send_byte(bad_dim());         // bad col count
				end else begin
					send_byte(`ASCII_ZERO + 8'(cur_cols));
					k = $urandom % (cur_rows * cur_cols);
					for (int i = 0; i < k; i++)
						send_byte(`ASCII_ZERO + 8'(cur[i]));
					send_byte(random_non_digit());
				end
			end
			wait_quiet();
			check_eq("parse_error pulses", perr_cnt - base_perr, 1);
			check_eq("echo bytes after bad input", rx_q.size(), 0);
			check_eq("stored_count after bad input", int'(stored_count), base_cnt);
			rx_q.delete();
			write_and_check("echo after bad input");   // parser recovered
		end
		end_test(3, "bad input");

		start_test();
		apply_reset();
		base_rd = rd_cnt;
		for (int m = 0; m < 3; m++)
			write_and_check("ring echo");        // third one lands in slot 0
		for (int s = 0; s < 2; s++) begin
			request_print(s);
			expect_slot(s);
			wait_quiet();
			compare_text("slot print");
		end
		check_eq("rd_error pulses", rd_cnt - base_rd, 0);
		end_test(4, "print ring");

		start_test();
		apply_reset();
		write_and_check("single echo");
		base_rd = rd_cnt;
		request_print(1);
		repeat (2 * FRAME) @(negedge clk);
		check_eq("rd_error pulses", rd_cnt - base_rd, 1);
		check_eq("bytes for empty slot", rx_q.size(), 0);
		check_eq("print_busy", int'(print_busy), 0);
		end_test(5, "empty slot");

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* verilog/mat_if.sv */
/*
 * matrix transfer interfaces
 * parser to store write path and store to printer job path
 */
`timescale 1ns/1ps

// complete matrix from the parser, single cycle strobe
interface mat_wr_if;
	import mat_pkg::*;

	logic      valid;
	dim_t      rows;
	dim_t      cols;
	mat_flat_t data;

	modport src (output valid, rows, cols, data);
	modport dst (input valid, rows, cols, data);
endinterface

// print job, fields held until busy falls
interface mat_print_if;
	import mat_pkg::*;

	logic      start;
	dim_t      rows;
	dim_t      cols;
	mat_flat_t data;
	logic      busy;     // printer side

	modport job (output start, rows, cols, data, input busy);
	modport fmt (input start, rows, cols, data, output busy);
endinterface

/* verilog/mat_pkg.sv */
/*
 * matrix front end types
 * width typedefs and the FSM state encodings
 */
`include "mat_consts.svh"

package mat_pkg;

	// ========================================
	// widths with a meaning
	typedef logic [2:0] dim_t;                      // row or col count, 1..5
	typedef logic [`MAT_ELEM_BITS-1:0] elem_t;      // one element value
	typedef logic [`MAT_MAX_DIM*`MAT_MAX_DIM*`MAT_ELEM_BITS-1:0] mat_flat_t; // elem 0 in low bits
	typedef logic [$clog2(`MAT_SLOTS)-1:0] slot_t;  // store slot index
	typedef logic [7:0] byte_t;                     // uart byte

	// ========================================
	// state machines
	typedef enum logic [1:0] {
		PS_ROWS,     // waiting for row digit
		PS_COLS,     // waiting for col digit
		PS_ELEMS,    // collecting element digits
		PS_REPORT    // one cycle of wr.valid
	} parse_state_e;

	typedef enum logic [2:0] {
		PR_IDLE,
		PR_DIGIT,
		PR_SEP,
		PR_CR,
		PR_LF
	} print_state_e;

	// shared by rx and tx
	typedef enum logic [1:0] {
		U_IDLE,
		U_START,
		U_DATA,
		U_STOP
	} uart_state_e;

endpackage

/* verilog/mat_top.sv */
/*
 * matrix entry front end
 * uart in, parse, store in a 2-slot ring, echo and print back over uart
 */
`timescale 1ns/1ps

module mat_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       uart_rxd,
	output logic       uart_txd,
	input  logic       print_req,
	input  logic       slot_sel,
	output logic [1:0] stored_count,
	output logic       parse_error,
	output logic       rd_error,
	output logic       print_busy
);

	logic [7:0] rx_data;
	logic       rx_done;
	logic [7:0] tx_data;
	logic       tx_en;
	logic       tx_busy;

	mat_wr_if    wr_if ();    // parser to store
	mat_print_if prn_if ();   // store to printer

	// ========================================
	// serial side
	uart_rx u_rx (
		.clk     (clk),
		.rst_n   (rst_n),
		.rxd     (uart_rxd),
		.rx_data (rx_data),
		.rx_done (rx_done)
	);

	uart_tx u_tx (
		.clk     (clk),
		.rst_n   (rst_n),
		.tx_en   (tx_en),
		.tx_data (tx_data),
		.txd     (uart_txd),
		.tx_busy (tx_busy)
	);

	// ========================================
	// matrix path
	matrix_parser u_parser (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_data     (rx_data),
		.rx_done     (rx_done),
		.wr          (wr_if),
		.parse_error (parse_error)
	);

	matrix_store u_store (
		.clk          (clk),
		.rst_n        (rst_n),
		.wr           (wr_if),
		.prn          (prn_if),
		.print_req    (print_req),
		.slot_sel     (slot_sel),
		.stored_count (stored_count),
		.rd_error     (rd_error),
		.print_busy   (print_busy)
	);

	matrix_printer u_printer (
		.clk     (clk),
		.rst_n   (rst_n),
		.prn     (prn_if),
		.tx_en   (tx_en),
		.tx_data (tx_data),
		.tx_busy (tx_busy)
	);

endmodule

/* verilog/matrix_parser.sv */
/*
 * ASCII matrix parser
 * rows digit, cols digit, then rows*cols element digits in row-major order
 */
`timescale 1ns/1ps
`include "mat_consts.svh"

module matrix_parser (
	input  logic           clk,
	input  logic           rst_n,
	input  mat_pkg::byte_t rx_data,
	input  logic           rx_done,
	mat_wr_if.src          wr,
	output logic           parse_error
);
	import mat_pkg::*;

	localparam int ELEMS = `MAT_MAX_DIM * `MAT_MAX_DIM;
	localparam int CW = $clog2(ELEMS + 1);
	localparam byte_t ASCII_NINE = `ASCII_ZERO + 8'd9;

	parse_state_e  state;
	dim_t          rows_q;
	dim_t          cols_q;
	logic [CW-1:0] remain;     // elements still expected
	logic [CW-1:0] idx;        // next element slot
	mat_flat_t     data_q;
	logic          is_digit;
	elem_t         digit;
	logic          dim_ok;

	// ========================================
	// byte classification
	assign is_digit = (rx_data >= `ASCII_ZERO) && (rx_data <= ASCII_NINE);
	assign digit    = elem_t'(rx_data - `ASCII_ZERO);
	assign dim_ok   = is_digit && (digit != '0) && (digit <= `MAT_MAX_DIM);

	// ========================================
	// protocol FSM
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= PS_ROWS;
			rows_q      <= '0;
			cols_q      <= '0;
			remain      <= '0;
			idx         <= '0;
			parse_error <= 1'b0;
		end else begin
			parse_error <= 1'b0;
			case (state)
				PS_ROWS: begin
					if (rx_done) begin
						if (dim_ok) begin
							rows_q <= dim_t'(digit);
							state  <= PS_COLS;
						end else begin
							parse_error <= 1'b1;
						end
					end
				end
				PS_COLS: begin
					if (rx_done) begin
						if (dim_ok) begin
							cols_q <= dim_t'(digit);
							remain <= CW'(rows_q) * CW'(digit);
							idx    <= '0;
							state  <= PS_ELEMS;
						end else begin
							parse_error <= 1'b1;
							state       <= PS_ROWS;
						end
					end
				end
				PS_ELEMS: begin
					if (rx_done) begin
						if (is_digit) begin
							idx    <= idx + 1'b1;
							remain <= remain - 1'b1;
							if (remain == CW'(1))
								state <= PS_REPORT;    // last element in
						end else begin
							parse_error <= 1'b1;   // abort this matrix
							state       <= PS_ROWS;
						end
					end
				end
				PS_REPORT: state <= PS_ROWS;
				default:   state <= PS_ROWS;
			endcase
		end
	end

	// element packing, elem 0 lands in the low nibble
	always_ff @(posedge clk) begin
		if (state == PS_ELEMS && rx_done && is_digit)
			data_q[idx*`MAT_ELEM_BITS +: `MAT_ELEM_BITS] <= digit;
	end

	assign wr.valid = (state == PS_REPORT);
	assign wr.rows  = rows_q;
	assign wr.cols  = cols_q;
	assign wr.data  = data_q;

	a_dims_nonzero : assert property (@(posedge clk) disable iff (!rst_n)
		wr.valid |-> (wr.rows != '0 && wr.cols != '0))
		else $error("matrix_parser: write with zero dimension");

endmodule

/* verilog/matrix_printer.sv */
/*
 * matrix printer
 * one line per row, digits split by spaces, CR LF after each row
 */
`timescale 1ns/1ps
`include "mat_consts.svh"

module matrix_printer (
	input  logic           clk,
	input  logic           rst_n,
	mat_print_if.fmt       prn,
	output logic           tx_en,
	output mat_pkg::byte_t tx_data,
	input  logic           tx_busy
);
	import mat_pkg::*;

	print_state_e state;
	dim_t         rows_q;
	dim_t         cols_q;
	dim_t         r_idx;
	dim_t         c_idx;
	mat_flat_t    data_q;      // next element in the low nibble
	logic         can_send;
	logic         last_col;
	logic         last_row;
	byte_t        next_byte;

	// tx_busy only rises the cycle after tx_en, so skip that cycle too
	assign can_send = !tx_busy && !tx_en;
	assign last_col = (c_idx == cols_q - 1'b1);
	assign last_row = (r_idx == rows_q - 1'b1);
	assign prn.busy = (state != PR_IDLE);

	always_comb begin
		case (state)
			PR_DIGIT: next_byte = `ASCII_ZERO + byte_t'(data_q[`MAT_ELEM_BITS-1:0]);
			PR_SEP:   next_byte = `ASCII_SPACE;
			PR_CR:    next_byte = `ASCII_CR;
			PR_LF:    next_byte = `ASCII_LF;
			default:  next_byte = `ASCII_SPACE;
		endcase
	end

	// ========================================
	// row and column walk
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= PR_IDLE;
			r_idx <= '0;
			c_idx <= '0;
			tx_en <= 1'b0;
		end else begin
			tx_en <= 1'b0;
			case (state)
				PR_IDLE: begin
					if (prn.start) begin
						r_idx <= '0;
						c_idx <= '0;
						state <= PR_DIGIT;
					end
				end
				PR_DIGIT: begin
					if (can_send) begin
						tx_en <= 1'b1;
						state <= last_col ? PR_CR : PR_SEP;   // no space at row end
					end
				end
				PR_SEP: begin
					if (can_send) begin
						tx_en <= 1'b1;
						c_idx <= c_idx + 1'b1;
						state <= PR_DIGIT;
					end
				end
				PR_CR: begin
					if (can_send) begin
						tx_en <= 1'b1;
						state <= PR_LF;
					end
				end
				PR_LF: begin
					if (can_send) begin
						tx_en <= 1'b1;
						c_idx <= '0;
						if (last_row) begin
							state <= PR_IDLE;    // busy drops with the final LF
						end else begin
							r_idx <= r_idx + 1'b1;
							state <= PR_DIGIT;
						end
					end
				end
				default: state <= PR_IDLE;
			endcase
		end
	end

	// job latch and byte register
	always_ff @(posedge clk) begin
		if (state == PR_IDLE && prn.start) begin
			rows_q <= prn.rows;
			cols_q <= prn.cols;
			data_q <= prn.data;
		end else if (state == PR_DIGIT && can_send) begin
			data_q <= data_q >> `MAT_ELEM_BITS;
		end
		if (state != PR_IDLE && can_send)
			tx_data <= next_byte;
	end

endmodule

/* verilog/matrix_store.sv */
/*
 * two-slot ring store
 * keeps parsed matrices and queues echo and print jobs for the printer
 */
`timescale 1ns/1ps
`include "mat_consts.svh"

module matrix_store (
	input  logic           clk,
	input  logic           rst_n,
	mat_wr_if.dst          wr,
	mat_print_if.job       prn,
	input  logic           print_req,
	input  mat_pkg::slot_t slot_sel,
	output logic [1:0]     stored_count,
	output logic           rd_error,
	output logic           print_busy
);
	import mat_pkg::*;

	dim_t                  slot_rows [`MAT_SLOTS];
	dim_t                  slot_cols [`MAT_SLOTS];
	mat_flat_t             slot_data [`MAT_SLOTS];
	logic [`MAT_SLOTS-1:0] slot_valid;
	slot_t                 wr_ptr;     // oldest slot, overwritten next
	logic                  pend;       // one job waiting
	slot_t                 pend_slot;
	logic                  job_start;
	dim_t                  job_rows;
	dim_t                  job_cols;
	mat_flat_t             job_data;
	logic                  issue;

	assign issue      = pend && !prn.busy && !job_start;
	assign print_busy = pend | job_start | prn.busy;   // start cycle counts as busy

	// ========================================
	// slot bookkeeping and job queue
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_valid   <= '0;
			wr_ptr       <= '0;
			stored_count <= '0;
			pend         <= 1'b0;
			pend_slot    <= '0;
			job_start    <= 1'b0;
			rd_error     <= 1'b0;
		end else begin
			rd_error  <= 1'b0;
			job_start <= issue;
			if (wr.valid) begin
				slot_valid[wr_ptr] <= 1'b1;
				wr_ptr             <= wr_ptr + 1'b1;
				if (stored_count != 2'(`MAT_SLOTS))
					stored_count <= stored_count + 1'b1;   // saturates
				pend      <= 1'b1;      // echo wins over a waiting print
				pend_slot <= wr_ptr;
			end else if (print_req && !slot_valid[slot_sel]) begin
				rd_error <= 1'b1;
			end else if (print_req && !print_busy) begin
				pend      <= 1'b1;
				pend_slot <= slot_sel;
			end else if (issue) begin
				pend <= 1'b0;
			end
		end
	end

	// slot contents and the job held for the printer
	always_ff @(posedge clk) begin
		if (wr.valid) begin
			slot_rows[wr_ptr] <= wr.rows;
			slot_cols[wr_ptr] <= wr.cols;
			slot_data[wr_ptr] <= wr.data;
		end
		if (issue) begin
			job_rows <= slot_rows[pend_slot];
			job_cols <= slot_cols[pend_slot];
			job_data <= slot_data[pend_slot];
		end
	end

	assign prn.start = job_start;
	assign prn.rows  = job_rows;
	assign prn.cols  = job_cols;
	assign prn.data  = job_data;

endmodule

/* verilog/uart_rx.sv */
/*
 * UART receiver
 * 8N1 with mid-bit sampling, one rx_done strobe per good frame
 */
`timescale 1ns/1ps
`include "mat_consts.svh"

module uart_rx (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           rxd,
	output mat_pkg::byte_t rx_data,
	output logic           rx_done
);
	import mat_pkg::*;

	localparam int CPB = `UART_CLKS_PER_BIT;
	localparam int BW = $clog2(CPB);
	localparam logic [BW-1:0] HALF = BW'(CPB / 2 - 1);   // middle of start bit
	localparam logic [BW-1:0] FULL = BW'(CPB - 1);       // one whole bit

	logic          rx_s1;
	logic          rx_s2;      // synchronised line
	uart_state_e   state;
	logic [BW-1:0] baud_cnt;
	logic [2:0]    bit_cnt;
	byte_t         shreg;

	// two-flop synchroniser, idles high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
		end else begin
			rx_s1 <= rxd;
			rx_s2 <= rx_s1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= U_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			rx_done  <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			case (state)
				U_IDLE: begin
					baud_cnt <= '0;
					if (!rx_s2)
						state <= U_START;      // falling edge seen
				end
				U_START: begin
					if (baud_cnt == HALF) begin
						baud_cnt <= '0;
						bit_cnt  <= '0;
						state    <= rx_s2 ? U_IDLE : U_DATA;   // high here is a glitch
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				U_DATA: begin
					if (baud_cnt == FULL) begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= U_STOP;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				U_STOP: begin
					if (baud_cnt == FULL) begin
						baud_cnt <= '0;
						state    <= U_IDLE;
						rx_done  <= rx_s2;      // framing error drops the byte
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= U_IDLE;
			endcase
		end
	end

	// data path, lsb arrives first
	always_ff @(posedge clk) begin
		if (state == U_DATA && baud_cnt == FULL)
			shreg <= {rx_s2, shreg[7:1]};
		if (state == U_STOP && baud_cnt == FULL)
			rx_data <= shreg;
	end

	a_done_single : assert property (@(posedge clk) disable iff (!rst_n)
		rx_done |=> !rx_done)
		else $error("uart_rx: rx_done held for two cycles");

endmodule

/* verilog/uart_tx.sv */
/*
 * UART transmitter
 * start bit, 8 data bits lsb first, stop bit; busy for the whole frame
 */
`timescale 1ns/1ps
`include "mat_consts.svh"

module uart_tx (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           tx_en,
	input  mat_pkg::byte_t tx_data,
	output logic           txd,
	output logic           tx_busy
);
	import mat_pkg::*;

	localparam int CPB = `UART_CLKS_PER_BIT;
	localparam int BW = $clog2(CPB);
	localparam logic [BW-1:0] FULL = BW'(CPB - 1);

	uart_state_e   state;
	logic [BW-1:0] baud_cnt;
	logic [2:0]    bit_cnt;
	byte_t         shreg;
	logic          bit_end;

	assign bit_end = (baud_cnt == FULL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= U_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			txd      <= 1'b1;     // line idles high
			tx_busy  <= 1'b0;
		end else begin
			baud_cnt <= (state == U_IDLE || bit_end) ? '0 : baud_cnt + 1'b1;
			case (state)
				U_IDLE: begin
					if (tx_en) begin
						state   <= U_START;
						txd     <= 1'b0;
						tx_busy <= 1'b1;
					end
				end
				U_START: begin
					if (bit_end) begin
						bit_cnt <= '0;
						txd     <= shreg[0];     // bit 0
						state   <= U_DATA;
					end
				end
				U_DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							txd   <= 1'b1;       // stop bit
							state <= U_STOP;
						end else begin
							txd <= shreg[0];
						end
					end
				end
				U_STOP: begin
					if (bit_end) begin
						state   <= U_IDLE;
						tx_busy <= 1'b0;
					end
				end
				default: state <= U_IDLE;
			endcase
		end
	end

	// load on accept, shift once per bit after the start bit
	always_ff @(posedge clk) begin
		if (state == U_IDLE && tx_en)
			shreg <= tx_data;
		else if ((state == U_START || state == U_DATA) && bit_end)
			shreg <= shreg >> 1;
	end

	a_no_overrun : assert property (@(posedge clk) disable iff (!rst_n)
		tx_busy |-> !tx_en)
		else $error("uart_tx: tx_en while busy");

endmodule
